// File: hdl/tlb_pkg.sv
/*
 * TLB package: sizing constants, RAM entry formats and the
 * configuration word and stage-to-stage result types
 */
`default_nettype none

package tlb_pkg;

   ////////////////////////////////////////
   // Address and page sizing
   ////////////////////////////////////////
   localparam int VADDR_WIDTH       = 32;
   localparam int PADDR_WIDTH       = 40;
   localparam int PAGE_OFFSET_WIDTH = 12; // 4 kB pages
   localparam int VPN_WIDTH         = VADDR_WIDTH - PAGE_OFFSET_WIDTH;
   localparam int PPN_WIDTH         = PADDR_WIDTH - PAGE_OFFSET_WIDTH;

   ////////////////////////////////////////
   // Organisation
   ////////////////////////////////////////
   localparam int N_SETS         = 8;
   localparam int SET_WIDTH      = 3;  // Low VPN bits
   localparam int N_OFFSETS      = 4;  // Entries per set per bank
   localparam int OFFSET_WIDTH   = 2;
   localparam int N_BANKS        = 2;
   localparam int BANK_WIDTH     = 1;
   localparam int VA_INDEX_WIDTH = SET_WIDTH + OFFSET_WIDTH;
   localparam int PA_INDEX_WIDTH = VA_INDEX_WIDTH + BANK_WIDTH;
   localparam int VA_DEPTH       = N_SETS * N_OFFSETS;
   localparam int PA_DEPTH       = VA_DEPTH * N_BANKS;

   // Config address: bit 6 selects PA, bits 5:1 VA index, bit 0 bank
   localparam int CFG_ADDR_WIDTH = 7;
   localparam int CFG_DATA_WIDTH = 32;

   typedef struct packed {
      logic                 valid;
      logic                 read_ok;
      logic                 write_ok;
      logic [VPN_WIDTH-1:0] vpn;
   } va_entry_t;

   typedef struct packed {
      logic [PPN_WIDTH-1:0] ppn;
   } pa_entry_t;

   localparam int VA_PAD_WIDTH = CFG_DATA_WIDTH - $bits(va_entry_t);
   localparam int PA_PAD_WIDTH = CFG_DATA_WIDTH - $bits(pa_entry_t);

   // One config word, read as a tag entry or as a page entry
   typedef union packed {
      struct packed {
         logic [VA_PAD_WIDTH-1:0] pad;
         va_entry_t               entry;
      } va;
      struct packed {
         logic [PA_PAD_WIDTH-1:0] pad;
         pa_entry_t               entry;
      } pa;
   } cfg_word_u;

   typedef struct packed {
      logic                         hit;
      logic                         prot;
      logic                         multi;
      logic [PA_INDEX_WIDTH-1:0]    pa_index;    // {set, offset, bank}
      logic [PAGE_OFFSET_WIDTH-1:0] page_offset;
   } search_res_t;

   typedef struct packed {
      logic hit;
      logic prot; // Only set together with hit
   } bank_hit_t;

endpackage

`default_nettype wire

// File: hdl/tlb_cfg_decode.sv
/*
 * TLB config decode: registers a config write and splits it into
 * per-bank VA write strobes and a PA write strobe
 */
`default_nettype none

module tlb_cfg_decode (
   input  logic                                clk_i,
   input  logic                                rst_ni,
   input  logic                                we_i,
   input  logic [tlb_pkg::CFG_ADDR_WIDTH-1:0]  waddr_i,
   input  tlb_pkg::cfg_word_u                  wdata_i,
   output logic [tlb_pkg::N_BANKS-1:0]         va_we_o,
   output logic [tlb_pkg::VA_INDEX_WIDTH-1:0]  va_windex_o,
   output tlb_pkg::va_entry_t                  va_wentry_o,
   output logic                                pa_we_o,
   output logic [tlb_pkg::PA_INDEX_WIDTH-1:0]  pa_windex_o,
   output tlb_pkg::pa_entry_t                  pa_wentry_o
);
   import tlb_pkg::*;

   logic                      we_q;
   logic [CFG_ADDR_WIDTH-1:0] waddr_q;
   cfg_word_u                 wdata_q;
   logic                      sel_pa;

   always_ff @(posedge clk_i) begin
      if (!rst_ni) begin
         we_q <= 1'b0;
      end else begin
         we_q <= we_i;
      end
   end

   always_ff @(posedge clk_i) begin
      waddr_q <= waddr_i;
      wdata_q <= wdata_i;
   end

   assign sel_pa = waddr_q[CFG_ADDR_WIDTH-1]; // Top address bit picks the PA RAM

   always_comb begin
      for (int b = 0; b < N_BANKS; b++) begin
         va_we_o[b] = we_q && !sel_pa && (waddr_q[BANK_WIDTH-1:0] == BANK_WIDTH'(b));
      end
      // Word is decoded only in the reading that the select asks for
      va_wentry_o = sel_pa ? '0 : wdata_q.va.entry;
      pa_wentry_o = sel_pa ? wdata_q.pa.entry : '0;
   end

   assign va_windex_o = waddr_q[VA_INDEX_WIDTH+BANK_WIDTH-1:BANK_WIDTH];
   assign pa_we_o     = we_q && sel_pa;
   assign pa_windex_o = waddr_q[PA_INDEX_WIDTH-1:0]; // Same layout as search pa_index

endmodule

`default_nettype wire

// File: hdl/tlb_va_bank.sv
/*
 * TLB VA bank: one tag RAM with a registered read, followed by the
 * tag compare and the read/write permission check
 */
`default_nettype none

module tlb_va_bank (
   input  logic                                clk_i,
   input  logic                                we_i,
   input  logic [tlb_pkg::VA_INDEX_WIDTH-1:0]  windex_i,
   input  tlb_pkg::va_entry_t                  wentry_i,
   input  logic [tlb_pkg::VA_INDEX_WIDTH-1:0]  rindex_i,
   input  logic [tlb_pkg::VPN_WIDTH-1:0]       vpn_i,
   input  logic                                rw_i,
   output tlb_pkg::bank_hit_t                  result_o
);
   import tlb_pkg::*;

   va_entry_t tag_ram [VA_DEPTH];
   va_entry_t entry_q;
   logic      match;
   logic      allowed;

   ////////////////////////////////////////
   // Tag RAM
   ////////////////////////////////////////
   always_ff @(posedge clk_i) begin
      if (we_i) begin
         tag_ram[windex_i] <= wentry_i;
      end
   end

   // Single port, read every cycle
   always_ff @(posedge clk_i) begin
      entry_q <= tag_ram[rindex_i];
   end

   ////////////////////////////////////////
   // Compare
   ////////////////////////////////////////
   assign match   = entry_q.valid && (entry_q.vpn == vpn_i);
   assign allowed = rw_i ? entry_q.write_ok : entry_q.read_ok; // rw_i high for a write

   always_comb begin
      result_o.hit  = match;
      result_o.prot = match && !allowed;
   end

endmodule

`default_nettype wire

// File: hdl/tlb_search.sv
/*
 * TLB execute stage: walks the offsets of one set over all VA banks,
 * stops on the first hit and resolves the winning bank
 */
`default_nettype none

module tlb_search (
   input  logic                                clk_i,
   input  logic                                rst_ni,
   input  logic                                start_i,
   input  logic [tlb_pkg::VADDR_WIDTH-1:0]     addr_i,
   input  logic                                rw_i,
   input  logic                                sent_i,
   input  logic [tlb_pkg::N_BANKS-1:0]         va_we_i,
   input  logic [tlb_pkg::VA_INDEX_WIDTH-1:0]  va_windex_i,
   input  tlb_pkg::va_entry_t                  va_wentry_i,
   output logic                                busy_o,
   output logic                                done_o,
   output tlb_pkg::search_res_t                result_o
);
   import tlb_pkg::*;

   typedef enum logic [1:0] {IDLE, LOOKUP, WAIT_SENT} state_t;

   state_t                    state_q, state_d;
   logic [VADDR_WIDTH-1:0]    addr_q;
   logic                      rw_q;
   logic [OFFSET_WIDTH-1:0]   offset_q;
   logic [OFFSET_WIDTH-1:0]   offset_dly_q;  // Offset of the bank results now visible
   logic                      rd_valid_q;    // A read was issued last cycle
   logic [VPN_WIDTH-1:0]      vpn;
   logic [SET_WIDTH-1:0]      set;
   logic [VA_INDEX_WIDTH-1:0] rindex;
   bank_hit_t [N_BANKS-1:0]   bank_res;
   logic                      any_hit;
   logic                      multi;
   logic [BANK_WIDTH-1:0]     win_bank;

   assign vpn    = addr_q[VADDR_WIDTH-1:PAGE_OFFSET_WIDTH];
   assign set    = vpn[SET_WIDTH-1:0];
   assign rindex = {set, offset_q};
   assign busy_o = (state_q != IDLE);

   ////////////////////////////////////////
   // Search FSM
   ////////////////////////////////////////
   always_comb begin
      state_d = state_q;
      unique case (state_q)
         IDLE: begin
            if (start_i) state_d = LOOKUP;
         end
         LOOKUP: begin
            if (done_o) state_d = WAIT_SENT;
         end
         WAIT_SENT: begin
            if (sent_i) state_d = IDLE; // Output accepted downstream
         end
         default: state_d = IDLE;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (!rst_ni) begin
         state_q      <= IDLE;
         offset_q     <= '0;
         offset_dly_q <= '0;
         rd_valid_q   <= 1'b0;
      end else begin
         state_q      <= state_d;
         offset_dly_q <= offset_q;
         rd_valid_q   <= (state_q == LOOKUP) && !done_o;
         if (state_q == IDLE) begin
            offset_q <= '0;
         end else if (state_q == LOOKUP) begin
            offset_q <= offset_q + 1'b1;
         end
      end
   end

   // Lookup request, held for the whole search
   always_ff @(posedge clk_i) begin
      if (state_q == IDLE && start_i) begin
         addr_q <= addr_i;
         rw_q   <= rw_i;
      end
   end

   for (genvar b = 0; b < N_BANKS; b++) begin : g_bank
      tlb_va_bank u_bank (
         .clk_i    (clk_i),
         .we_i     (va_we_i[b]),
         .windex_i (va_windex_i),
         .wentry_i (va_wentry_i),
         .rindex_i (rindex),
         .vpn_i    (vpn),
         .rw_i     (rw_q),
         .result_o (bank_res[b])
      );
   end

   // Lowest hitting bank wins, a second hit in the same cycle is a multi-hit
   always_comb begin
      any_hit  = 1'b0;
      multi    = 1'b0;
      win_bank = '0;
      for (int i = N_BANKS - 1; i >= 0; i--) begin
         if (bank_res[i].hit) begin
            if (any_hit) multi = 1'b1;
            any_hit  = 1'b1;
            win_bank = BANK_WIDTH'(i);
         end
      end
   end

   assign done_o = rd_valid_q && (any_hit || offset_dly_q == OFFSET_WIDTH'(N_OFFSETS - 1));

   always_comb begin
      result_o.hit         = any_hit;
      result_o.prot        = bank_res[win_bank].prot;
      result_o.multi       = multi;
      result_o.pa_index    = {set, offset_dly_q, win_bank};
      result_o.page_offset = addr_q[PAGE_OFFSET_WIDTH-1:0];
   end

endmodule

`default_nettype wire

// File: hdl/tlb_result.sv
/*
 * TLB result stage: PA RAM lookup on a clean hit and the output
 * FSM that holds the result until it is accepted
 */
`default_nettype none

module tlb_result (
   input  logic                                clk_i,
   input  logic                                rst_ni,
   input  logic                                done_i,
   input  tlb_pkg::search_res_t                result_i,
   input  logic                                pa_we_i,
   input  logic [tlb_pkg::PA_INDEX_WIDTH-1:0]  pa_windex_i,
   input  tlb_pkg::pa_entry_t                  pa_wentry_i,
   input  logic                                out_ready_i,
   output logic                                sent_o,
   output logic                                out_valid_o,
   output logic                                hit_o,
   output logic                                miss_o,
   output logic                                prot_o,
   output logic                                multi_o,
   output logic [tlb_pkg::PADDR_WIDTH-1:0]     out_addr_o
);
   import tlb_pkg::*;

   typedef enum logic [1:0] {OUT_IDLE, READ_PA, SEND} out_state_t;

   out_state_t                   state_q, state_d;
   pa_entry_t                    pa_ram [PA_DEPTH];
   logic [PA_INDEX_WIDTH-1:0]    pa_index_q;
   logic [PPN_WIDTH-1:0]         ppn_q;
   logic [PAGE_OFFSET_WIDTH-1:0] page_off_q;
   logic                         accept;
   logic                         plain_hit;

   assign accept    = (state_q == OUT_IDLE) && done_i;
   assign plain_hit = result_i.hit && !result_i.prot && !result_i.multi; // Needs a translation

   ////////////////////////////////////////
   // Output FSM
   ////////////////////////////////////////
   always_comb begin
      state_d = state_q;
      unique case (state_q)
         OUT_IDLE: begin
            if (done_i) state_d = plain_hit ? READ_PA : SEND;
         end
         READ_PA: state_d = SEND;
         SEND: begin
            if (out_ready_i) state_d = OUT_IDLE;
         end
         default: state_d = OUT_IDLE;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (!rst_ni) begin
         state_q <= OUT_IDLE;
         hit_o   <= 1'b0;
         miss_o  <= 1'b0;
         prot_o  <= 1'b0;
         multi_o <= 1'b0;
      end else begin
         state_q <= state_d;
         if (accept) begin
            hit_o   <= result_i.hit;
            miss_o  <= !result_i.hit;
            prot_o  <= result_i.prot;
            multi_o <= result_i.multi;
         end
      end
   end

   // PA RAM
   always_ff @(posedge clk_i) begin
      if (pa_we_i) begin
         pa_ram[pa_windex_i] <= pa_wentry_i;
      end
   end

   // Address is only meaningful on a clean hit, zero otherwise
   always_ff @(posedge clk_i) begin
      if (accept) begin
         pa_index_q <= result_i.pa_index;
         page_off_q <= plain_hit ? result_i.page_offset : '0;
         ppn_q      <= '0;
      end else if (state_q == READ_PA) begin
         ppn_q <= pa_ram[pa_index_q].ppn;
      end
   end

   assign out_valid_o = (state_q == SEND);
   assign sent_o      = out_valid_o && out_ready_i;
   assign out_addr_o  = {ppn_q, page_off_q};

endmodule

`default_nettype wire

// File: hdl/l2_tlb.sv
/*
 * L2 TLB top: config decode, set search and result stages
 */
`default_nettype none

module l2_tlb (
   input  logic                                clk_i,
   input  logic                                rst_ni,
   input  logic                                we_i,
   input  logic [tlb_pkg::CFG_ADDR_WIDTH-1:0]  waddr_i,
   input  tlb_pkg::cfg_word_u                  wdata_i,
   input  logic                                start_i,
   input  logic [tlb_pkg::VADDR_WIDTH-1:0]     addr_i,
   input  logic                                rw_i,      // 1 for a write access
   output logic                                busy_o,
   input  logic                                out_ready_i,
   output logic                                out_valid_o,
   output logic                                hit_o,
   output logic                                miss_o,
   output logic                                prot_o,
   output logic                                multi_o,
   output logic [tlb_pkg::PADDR_WIDTH-1:0]     out_addr_o
);
   import tlb_pkg::*;

   logic [N_BANKS-1:0]        va_we;
   logic [VA_INDEX_WIDTH-1:0] va_windex;
   va_entry_t                 va_wentry;
   logic                      pa_we;
   logic [PA_INDEX_WIDTH-1:0] pa_windex;
   pa_entry_t                 pa_wentry;
   logic                      done;
   logic                      sent;
   search_res_t               search_res;

   tlb_cfg_decode u_decode (
      .clk_i, .rst_ni, .we_i, .waddr_i, .wdata_i,
      .va_we_o     (va_we),
      .va_windex_o (va_windex),
      .va_wentry_o (va_wentry),
      .pa_we_o     (pa_we),
      .pa_windex_o (pa_windex),
      .pa_wentry_o (pa_wentry)
   );

   tlb_search u_search (
      .clk_i, .rst_ni, .start_i, .addr_i, .rw_i,
      .sent_i      (sent),
      .va_we_i     (va_we),
      .va_windex_i (va_windex),
      .va_wentry_i (va_wentry),
      .busy_o,
      .done_o      (done),
      .result_o    (search_res)
   );

   tlb_result u_result (
      .clk_i, .rst_ni,
      .done_i      (done),
      .result_i    (search_res),
      .pa_we_i     (pa_we),
      .pa_windex_i (pa_windex),
      .pa_wentry_i (pa_wentry),
      .out_ready_i,
      .sent_o      (sent),
      .out_valid_o, .hit_o, .miss_o, .prot_o, .multi_o, .out_addr_o
   );

endmodule

`default_nettype wire

// File: testbench/tb_l2_tlb.sv
/*
 * L2 TLB testbench that replays config writes and lookups from the pattern
 * file and checks flags, translated address, latency and back-pressure
 */
`default_nettype none

module tb_l2_tlb;
   import tlb_pkg::*;

   localparam string PATTERN_FILE = "testbench/tlb_patterns.txt";
   localparam int    RESET_CYCLES = 16;
   localparam int    RECORD_CYCLES = 30;

   typedef struct packed {
      logic                      lookup;   // 0 for a config write
      logic [CFG_ADDR_WIDTH-1:0] cfg_addr;
      logic [31:0]               word;     // Config data or lookup address
      logic                      rw;
      logic                      hit;
      logic                      miss;
      logic                      prot;
      logic                      multi;
      logic [OFFSET_WIDTH-1:0]   offset;   // Offset where the hit is expected
      logic [PADDR_WIDTH-1:0]    out_addr;
   } record_t;

   typedef struct packed {
      logic                   hit;
      logic                   miss;
      logic                   prot;
      logic                   multi;
      logic [PADDR_WIDTH-1:0] addr;
   } result_t;

   logic                      clk_i = 1'b0;
   logic                      rst_ni;
   logic                      we_i;
   logic [CFG_ADDR_WIDTH-1:0] waddr_i;
   cfg_word_u                 wdata_i;
   logic                      start_i;
   logic [VADDR_WIDTH-1:0]    addr_i;
   logic                      rw_i;
   logic                      busy_o;
   logic                      out_ready_i;
   logic                      out_valid_o;
   logic                      hit_o;
   logic                      miss_o;
   logic                      prot_o;
   logic                      multi_o;
   logic [PADDR_WIDTH-1:0]    out_addr_o;

   record_t     records[$];
   int          errors = 0;
   int          checks = 0;
   int          cycle_count = 0;
   int          cycle_limit = 0;
   logic [31:0] lfsr_state = 32'h77a1;

   l2_tlb u_dut (
      .clk_i, .rst_ni, .we_i, .waddr_i, .wdata_i, .start_i, .addr_i, .rw_i, .busy_o,
      .out_ready_i, .out_valid_o, .hit_o, .miss_o, .prot_o, .multi_o, .out_addr_o
   );

   always #10 clk_i = ~clk_i;

   // Watchdog with its limit set once the pattern file is loaded
   always @(posedge clk_i) begin
      cycle_count = cycle_count + 1;
      if (cycle_count > cycle_limit) begin
         $display("Timeout after %0d cycles, the DUT stopped responding", cycle_count);
         $display("TESTS FAILED");
         $finish;
      end
   end

   ////////////////////////////////////////
   // Checks and helpers
   ////////////////////////////////////////
   task automatic check_value(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
      checks++;
      assert (expected === actual) else begin
         errors++;
         $display("[ERROR] %s: expected %0h, actual %0h", name, expected, actual);
      end
   endtask

   task automatic check_true(input logic cond, input string what);
      checks++;
      assert (cond === 1'b1) else begin
         errors++;
         $display("%s", what);
      end
   endtask

   // Fibonacci LFSR with taps 32 22 2 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic take_ready_bit(output logic b);
      lfsr_state = lfsr_next(lfsr_state);
      b = lfsr_state[0];
   endtask

   function automatic int expected_latency(input record_t rec);
      if (!rec.hit) return 6;                              // All four offsets compared
      if (rec.prot || rec.multi) return int'(rec.offset) + 3; // No PA read
      return int'(rec.offset) + 4;
   endfunction

   function automatic result_t read_outputs();
      return {hit_o, miss_o, prot_o, multi_o, out_addr_o};
   endfunction

   task automatic load_patterns(output logic ok);
      int                     fd;
      int                     code;
      logic [7:0]             tag;
      logic [8*160-1:0]       rest;
      logic [CFG_ADDR_WIDTH-1:0] a;
      logic [31:0]            w;
      logic                   rw;
      logic                   hit;
      logic                   miss;
      logic                   prot;
      logic                   multi;
      logic [OFFSET_WIDTH-1:0] offset;
      logic [PADDR_WIDTH-1:0] out_addr;
      ok = 1'b0;
      fd = $fopen(PATTERN_FILE, "r");
      if (fd != 0) begin
         ok = 1'b1;
         while ($fscanf(fd, " %s", tag) == 1) begin
            if (tag == "#") begin
               code = $fgets(rest, fd);   // Column description
            end else if (tag == "W") begin
               code = $fscanf(fd, "%h %h", a, w);
               if (code != 2) ok = 1'b0;
               records.push_back({1'b0, a, w, 5'b0, {OFFSET_WIDTH{1'b0}}, {PADDR_WIDTH{1'b0}}});
            end else begin
               code = $fscanf(fd, "%h %b %b %b %b %b %d %h", w, rw, hit, miss, prot, multi,
                              offset, out_addr);
               if (code != 8) ok = 1'b0;
               records.push_back({1'b1, {CFG_ADDR_WIDTH{1'b0}}, w, rw, hit, miss, prot,
                                  multi, offset, out_addr});
            end
         end
         $fclose(fd);
      end
   endtask

   ////////////////////////////////////////
   // Stimulus
   ////////////////////////////////////////
   task automatic cfg_write(input logic [CFG_ADDR_WIDTH-1:0] a, input logic [31:0] d);
      @(posedge clk_i);
      #2;
      we_i    = 1'b1;
      waddr_i = a;
      wdata_i = d;
      @(posedge clk_i);
      #2;
      we_i = 1'b0;
   endtask

   // Tag RAMs power up undefined
   task automatic clear_tags();
      for (int i = 0; i < N_BANKS * VA_DEPTH; i++) begin
         cfg_write(CFG_ADDR_WIDTH'(i), 32'h0);
      end
   endtask

   task automatic run_lookup(input int idx, input record_t rec);
      int      latency;
      logic    ready_bit;
      result_t held;
      @(posedge clk_i);
      #2;
      start_i = 1'b1;
      addr_i  = rec.word;
      rw_i    = rec.rw;
      latency = 0;
      do begin
         @(posedge clk_i);
         #2;
         latency++;
         start_i = (latency == 2);          // Second request while busy is ignored
         addr_i  = rec.word ^ 32'h5a5a_5000;
         rw_i    = !rec.rw;
         @(negedge clk_i);
         check_true(busy_o, $sformatf("busy_o low while lookup %0d was pending", idx));
      end while (!out_valid_o);
      check_value($sformatf("record %0d latency", idx), 64'(expected_latency(rec)),
                  64'(latency));
      held = read_outputs();
      check_value($sformatf("record %0d result", idx),
                  64'({rec.hit, rec.miss, rec.prot, rec.multi, rec.out_addr}), 64'(held));
      // Random back-pressure until the handshake
      do begin
         @(posedge clk_i);
         #2;
         take_ready_bit(ready_bit);
         out_ready_i = ready_bit;
         @(negedge clk_i);
         check_true(out_valid_o && busy_o,
                    $sformatf("out_valid_o or busy_o dropped early in lookup %0d", idx));
         check_value($sformatf("record %0d held result", idx), 64'(held),
                     64'(read_outputs()));
      end while (!ready_bit);
      @(posedge clk_i);
      #2;
      out_ready_i = 1'b0;
      @(negedge clk_i);
      check_true(!busy_o && !out_valid_o,
                 $sformatf("busy_o or out_valid_o still high after lookup %0d", idx));
   endtask

   initial begin
      logic load_ok;
      rst_ni      = 1'b0;
      we_i        = 1'b0;
      waddr_i     = '0;
      wdata_i     = '0;
      start_i     = 1'b0;
      addr_i      = '0;
      rw_i        = 1'b0;
      out_ready_i = 1'b0;
      load_patterns(load_ok);
      cycle_limit = RESET_CYCLES + 2 * N_BANKS * VA_DEPTH + RECORD_CYCLES * records.size();
      repeat (RESET_CYCLES) @(posedge clk_i);
      #2;
      rst_ni = 1'b1;
      @(negedge clk_i);
      check_true(!busy_o && !out_valid_o, "busy_o or out_valid_o high after reset");
      if (!load_ok) begin
         errors++;
         $display("Pattern file %s is missing or malformed", PATTERN_FILE);
      end else begin
         clear_tags();
         for (int i = 0; i < records.size(); i++) begin
            if (records[i].lookup) begin
               run_lookup(i, records[i]);
            end else begin
               cfg_write(records[i].cfg_addr, records[i].word);
            end
         end
      end
      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: testbench/tlb_patterns.txt
# W <cfg_addr> <data>  with cfg_addr bit 6 selecting the PA RAM
# S <vaddr> <rw> <hit> <miss> <prot> <multi> <hit_offset> <out_addr>
W 08 00712341
W 48 0ABCDE12
W 0D 00700009
W 4D 00001234
W 1A 00600203
W 5A 08000001
W 1F 0057FFFB
W 2C 0070ACE5
W 2D 0070ACE5
W 36 0073FFF6
W 76 01111111
W 33 0073FFF6
W 73 02222222
W 37 00712346
W 77 0FEDCBA9
W 10 00300002
S 12341567 0 1 0 0 0 0 ABCDE12567
S 00009ABC 1 1 0 0 0 2 0001234ABC
S 55551000 0 0 1 0 0 0 0000000000
S 00002000 0 0 1 0 0 0 0000000000
S 00203FFF 1 1 0 1 0 1 0000000000
S 7FFFB010 0 1 0 1 0 3 0000000000
S 00203123 0 1 0 0 0 1 8000001123
S 0ACE5000 0 1 0 0 1 2 0000000000
S 3FFF6ABC 0 1 0 0 0 1 2222222ABC
S 12346001 1 1 0 0 0 3 FEDCBA9001

// File: filelist.f
hdl/tlb_pkg.sv
hdl/tlb_cfg_decode.sv
hdl/tlb_va_bank.sv
hdl/tlb_search.sv
hdl/tlb_result.sv
hdl/l2_tlb.sv
testbench/tb_l2_tlb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_l2_tlb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST) testbench/tlb_patterns.txt
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@if grep -q "TESTS FAILED" $(LOG); then \
		echo "Simulation reported failure"; exit 1; \
	elif ! grep -q "TESTS PASSED" $(LOG); then \
		echo "Simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
